//--- common/soc_periph_pkg.sv
/* Shared widths, address map, register offsets and event positions of the peripheral
   subsystem. Referenced by scoped names from every RTL file. */

package soc_periph_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;
    localparam int GPIO_W     = 32;
    localparam int TIMER_W    = 32;
    localparam int FC_EVT_W   = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [GPIO_W-1:0]     gpio_vec_t;
    typedef logic [TIMER_W-1:0]    timer_cnt_t;
    typedef logic [FC_EVT_W-1:0]   fc_events_t;

    // Decoded APB target
    typedef enum logic [1:0] {
        SLOT_GPIO  = 2'd0,
        SLOT_TIMER = 2'd1,
        SLOT_NONE  = 2'd2
    } periph_slot_e;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    localparam int SLOT_MSB = 11;
    localparam int SLOT_LSB = 8;

    localparam logic [SLOT_MSB-SLOT_LSB:0] GPIO_SLOT_ID  = 4'h0;
    localparam logic [SLOT_MSB-SLOT_LSB:0] TIMER_SLOT_ID = 4'h1;

    // Register offsets inside a slot
    localparam logic [SLOT_LSB-1:0] GPIO_DIR_OFS     = 8'h00;
    localparam logic [SLOT_LSB-1:0] GPIO_IN_OFS      = 8'h04;
    localparam logic [SLOT_LSB-1:0] GPIO_OUT_OFS     = 8'h08;
    localparam logic [SLOT_LSB-1:0] GPIO_INTEN_OFS   = 8'h0C;
    localparam logic [SLOT_LSB-1:0] GPIO_INTSTAT_OFS = 8'h10;

    localparam logic [SLOT_LSB-1:0] TIMER_CTRL_OFS  = 8'h00;
    localparam logic [SLOT_LSB-1:0] TIMER_COUNT_OFS = 8'h04;
    localparam logic [SLOT_LSB-1:0] TIMER_CMP_OFS   = 8'h08;

    // Timer control bits
    localparam int TIMER_CTRL_EN_BIT  = 0;
    localparam int TIMER_CTRL_REF_BIT = 1;

    // Positions in the fabric-controller event vector
    localparam int EVT_TIMER_POS   = 10;
    localparam int EVT_REF_CLK_POS = 14;
    localparam int EVT_GPIO_POS    = 15;

endpackage

//--- hdl/periph_apb_decoder.sv
/* APB address decoder: routes psel to the addressed peripheral and muxes the response back.
   Unmapped slots are answered here with an error. */

`timescale 1ns/1ps

module periph_apb_decoder (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    output logic                      gpio_psel_o,
    output logic                      timer_psel_o,

    input  soc_periph_pkg::apb_data_t gpio_prdata_i,
    input  logic                      gpio_pready_i,
    input  logic                      gpio_pslverr_i,
    input  soc_periph_pkg::apb_data_t timer_prdata_i,
    input  logic                      timer_pready_i,
    input  logic                      timer_pslverr_i
);

    soc_periph_pkg::periph_slot_e slot_d;
    soc_periph_pkg::periph_slot_e slot_q;
    logic                         access;

    // Slot classification
    always_comb begin
        case (paddr_i[soc_periph_pkg::SLOT_MSB:soc_periph_pkg::SLOT_LSB])
            soc_periph_pkg::GPIO_SLOT_ID:  slot_d = soc_periph_pkg::SLOT_GPIO;
            soc_periph_pkg::TIMER_SLOT_ID: slot_d = soc_periph_pkg::SLOT_TIMER;
            default:                       slot_d = soc_periph_pkg::SLOT_NONE;
        endcase
    end

    // Latch the target in the setup phase
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_q <= soc_periph_pkg::SLOT_NONE;
        end else if (psel_i && !penable_i) begin
            slot_q <= slot_d;
        end
    end

    assign gpio_psel_o  = psel_i && (slot_d == soc_periph_pkg::SLOT_GPIO);
    assign timer_psel_o = psel_i && (slot_d == soc_periph_pkg::SLOT_TIMER);

    assign access = psel_i & penable_i;

    ////////////////////////////////////////
    // Response mux
    ////////////////////////////////////////
    always_comb begin
        case (slot_q)
            soc_periph_pkg::SLOT_GPIO: begin
                prdata_o  = gpio_prdata_i;
                pready_o  = gpio_pready_i;
                pslverr_o = gpio_pslverr_i;
            end
            soc_periph_pkg::SLOT_TIMER: begin
                prdata_o  = timer_prdata_i;
                pready_o  = timer_pready_i;
                pslverr_o = timer_pslverr_i;
            end
            default: begin
                // Nothing mapped here, complete with an error
                prdata_o  = '0;
                pready_o  = access;
                pslverr_o = access;
            end
        endcase
    end

endmodule

//--- gpio/gpio_input_sync.sv
/* Two-flop synchronizer for the GPIO pads plus a delayed copy for rising-edge detection.
   rise_o pulses for one cycle per synchronized 0-to-1 transition. */

`timescale 1ns/1ps

module gpio_input_sync (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  soc_periph_pkg::gpio_vec_t pins_i,
    output soc_periph_pkg::gpio_vec_t sync_o,
    output soc_periph_pkg::gpio_vec_t rise_o
);

    soc_periph_pkg::gpio_vec_t sync1_q;
    soc_periph_pkg::gpio_vec_t sync2_q;
    soc_periph_pkg::gpio_vec_t prev_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= pins_i;
            sync2_q <= sync1_q;
            // One cycle older, for the edge compare
            prev_q  <= sync2_q;
        end
    end

    assign sync_o = sync2_q;
    assign rise_o = sync2_q & ~prev_q;

endmodule

//--- gpio/gpio_apb_regs.sv
/* GPIO register block on APB: direction, output, interrupt enable and write-1-to-clear
   status. The interrupt is the OR of all status bits. */

`timescale 1ns/1ps

module gpio_apb_regs (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    input  soc_periph_pkg::gpio_vec_t gpio_in_i,
    output soc_periph_pkg::gpio_vec_t gpio_out_o,
    output soc_periph_pkg::gpio_vec_t gpio_dir_o,
    output logic                      gpio_irq_o
);

    soc_periph_pkg::gpio_vec_t dir_q;
    soc_periph_pkg::gpio_vec_t out_q;
    soc_periph_pkg::gpio_vec_t inten_q;
    soc_periph_pkg::gpio_vec_t status_q;
    soc_periph_pkg::gpio_vec_t pins_sync;
    soc_periph_pkg::gpio_vec_t pins_rise;
    soc_periph_pkg::gpio_vec_t status_clr;
    logic [soc_periph_pkg::SLOT_LSB-1:0] ofs;
    logic                      access;
    logic                      ofs_valid;
    logic                      wr_en;

    gpio_input_sync sync_inst (
        .clk_i    ( clk_i     ),
        .arst_n_i ( arst_n_i  ),
        .pins_i   ( gpio_in_i ),
        .sync_o   ( pins_sync ),
        .rise_o   ( pins_rise )
    );

    assign ofs    = paddr_i[soc_periph_pkg::SLOT_LSB-1:0];
    assign access = psel_i & penable_i;

    ////////////////////////////////////////
    // Read mux and offset check
    ////////////////////////////////////////
    always_comb begin
        ofs_valid = 1'b1;
        case (ofs)
            soc_periph_pkg::GPIO_DIR_OFS:     prdata_o = dir_q;
            soc_periph_pkg::GPIO_IN_OFS:      prdata_o = pins_sync;
            soc_periph_pkg::GPIO_OUT_OFS:     prdata_o = out_q;
            soc_periph_pkg::GPIO_INTEN_OFS:   prdata_o = inten_q;
            soc_periph_pkg::GPIO_INTSTAT_OFS: prdata_o = status_q;
            default: begin
                prdata_o  = '0;
                ofs_valid = 1'b0;
            end
        endcase
    end

    assign pready_o  = access;
    assign pslverr_o = access & ~ofs_valid;
    assign wr_en     = access & pwrite_i & ofs_valid;

    assign status_clr = (wr_en && ofs == soc_periph_pkg::GPIO_INTSTAT_OFS) ? pwdata_i : '0;

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
        end else begin
            if (wr_en && ofs == soc_periph_pkg::GPIO_DIR_OFS)   dir_q   <= pwdata_i;
            if (wr_en && ofs == soc_periph_pkg::GPIO_OUT_OFS)   out_q   <= pwdata_i;
            if (wr_en && ofs == soc_periph_pkg::GPIO_INTEN_OFS) inten_q <= pwdata_i;
            // A new edge wins over a clear in the same cycle
            status_q <= (status_q & ~status_clr) | (pins_rise & inten_q);
        end
    end

    assign gpio_dir_o = dir_q;
    assign gpio_out_o = out_q;
    assign gpio_irq_o = |status_q;

endmodule

//--- timer/apb_timer.sv
/* 32-bit counter/compare timer on APB. Counts clocks or reference ticks, wraps to zero
   at the compare value and pulses the interrupt one cycle after each wrap. */

`timescale 1ns/1ps

module apb_timer (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    input  logic                      ref_tick_i,
    output logic                      timer_irq_o
);

    logic [1:0]                 ctrl_q;
    soc_periph_pkg::timer_cnt_t count_q;
    soc_periph_pkg::timer_cnt_t cmp_q;
    logic                       irq_q;
    logic [soc_periph_pkg::SLOT_LSB-1:0] ofs;
    logic                       access;
    logic                       ofs_valid;
    logic                       wr_en;
    logic                       tick;
    logic                       wrap;

    assign ofs    = paddr_i[soc_periph_pkg::SLOT_LSB-1:0];
    assign access = psel_i & penable_i;

    always_comb begin
        ofs_valid = 1'b1;
        case (ofs)
            soc_periph_pkg::TIMER_CTRL_OFS:  prdata_o = soc_periph_pkg::apb_data_t'(ctrl_q);
            soc_periph_pkg::TIMER_COUNT_OFS: prdata_o = count_q;
            soc_periph_pkg::TIMER_CMP_OFS:   prdata_o = cmp_q;
            default: begin
                prdata_o  = '0;
                ofs_valid = 1'b0;
            end
        endcase
    end

    assign pready_o  = access;
    assign pslverr_o = access & ~ofs_valid;
    assign wr_en     = access & pwrite_i & ofs_valid;

    ////////////////////////////////////////
    // Tick source and wrap
    ////////////////////////////////////////
    assign tick = ctrl_q[soc_periph_pkg::TIMER_CTRL_EN_BIT] &
                  (ctrl_q[soc_periph_pkg::TIMER_CTRL_REF_BIT] ? ref_tick_i : 1'b1);
    assign wrap = tick && (count_q == cmp_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q  <= '0;
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (wr_en && ofs == soc_periph_pkg::TIMER_CTRL_OFS) ctrl_q <= pwdata_i[1:0];
            if (wr_en && ofs == soc_periph_pkg::TIMER_CMP_OFS)  cmp_q  <= pwdata_i;
            // Software write to the count overrides counting
            if (wr_en && ofs == soc_periph_pkg::TIMER_COUNT_OFS) begin
                count_q <= pwdata_i;
            end else if (wrap) begin
                count_q <= '0;
            end else if (tick) begin
                count_q <= count_q + 1'b1;
            end
            irq_q <= wrap;
        end
    end

    assign timer_irq_o = irq_q;

endmodule

//--- hdl/ref_clk_edge_detect.sv
/* Brings the slow reference clock into the system clock domain and emits registered
   one-cycle pulses on its rising and falling edges. */

`timescale 1ns/1ps

module ref_clk_edge_detect (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic slow_clk_i,
    output logic rise_o,
    output logic fall_o
);

    logic sync1_q;
    logic sync2_q;
    logic prev_q;
    logic rise_q;
    logic fall_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            prev_q  <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end else begin
            sync1_q <= slow_clk_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            rise_q  <= sync2_q & ~prev_q;
            fall_q  <= ~sync2_q & prev_q;
        end
    end

    assign rise_o = rise_q;
    assign fall_o = fall_q;

endmodule

//--- hdl/soc_peripherals.sv
/* Peripheral subsystem top: APB decoder, GPIO, timer and reference-clock edge detector.
   Also builds the fabric-controller event vector. */

`timescale 1ns/1ps

module soc_peripherals (
    input  logic                       clk_i,
    input  logic                       arst_n_i,

    input  soc_periph_pkg::apb_addr_t  paddr_i,
    input  soc_periph_pkg::apb_data_t  pwdata_i,
    input  logic                       pwrite_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    output soc_periph_pkg::apb_data_t  prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,

    input  logic                       slow_clk_i,
    input  soc_periph_pkg::gpio_vec_t  gpio_in_i,
    output soc_periph_pkg::gpio_vec_t  gpio_out_o,
    output soc_periph_pkg::gpio_vec_t  gpio_dir_o,
    output soc_periph_pkg::fc_events_t fc_events_o
);

    logic                      gpio_psel;
    soc_periph_pkg::apb_data_t gpio_prdata;
    logic                      gpio_pready;
    logic                      gpio_pslverr;
    logic                      timer_psel;
    soc_periph_pkg::apb_data_t timer_prdata;
    logic                      timer_pready;
    logic                      timer_pslverr;
    logic                      gpio_irq;
    logic                      timer_irq;
    logic                      ref_rise;
    logic                      ref_fall;

    ////////////////////////////////////////
    // Bus
    ////////////////////////////////////////
    periph_apb_decoder decoder_inst (
        .clk_i           ( clk_i         ),
        .arst_n_i        ( arst_n_i      ),
        .paddr_i         ( paddr_i       ),
        .psel_i          ( psel_i        ),
        .penable_i       ( penable_i     ),
        .prdata_o        ( prdata_o      ),
        .pready_o        ( pready_o      ),
        .pslverr_o       ( pslverr_o     ),
        .gpio_psel_o     ( gpio_psel     ),
        .timer_psel_o    ( timer_psel    ),
        .gpio_prdata_i   ( gpio_prdata   ),
        .gpio_pready_i   ( gpio_pready   ),
        .gpio_pslverr_i  ( gpio_pslverr  ),
        .timer_prdata_i  ( timer_prdata  ),
        .timer_pready_i  ( timer_pready  ),
        .timer_pslverr_i ( timer_pslverr )
    );

    ////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////
    gpio_apb_regs gpio_inst (
        .clk_i      ( clk_i        ),
        .arst_n_i   ( arst_n_i     ),
        .paddr_i    ( paddr_i      ),
        .pwdata_i   ( pwdata_i     ),
        .pwrite_i   ( pwrite_i     ),
        .psel_i     ( gpio_psel    ),
        .penable_i  ( penable_i    ),
        .prdata_o   ( gpio_prdata  ),
        .pready_o   ( gpio_pready  ),
        .pslverr_o  ( gpio_pslverr ),
        .gpio_in_i  ( gpio_in_i    ),
        .gpio_out_o ( gpio_out_o   ),
        .gpio_dir_o ( gpio_dir_o   ),
        .gpio_irq_o ( gpio_irq     )
    );

    apb_timer timer_inst (
        .clk_i       ( clk_i         ),
        .arst_n_i    ( arst_n_i      ),
        .paddr_i     ( paddr_i       ),
        .pwdata_i    ( pwdata_i      ),
        .pwrite_i    ( pwrite_i      ),
        .psel_i      ( timer_psel    ),
        .penable_i   ( penable_i     ),
        .prdata_o    ( timer_prdata  ),
        .pready_o    ( timer_pready  ),
        .pslverr_o   ( timer_pslverr ),
        .ref_tick_i  ( ref_rise      ),
        .timer_irq_o ( timer_irq     )
    );

    ref_clk_edge_detect ref_edge_inst (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .slow_clk_i ( slow_clk_i ),
        .rise_o     ( ref_rise   ),
        .fall_o     ( ref_fall   )
    );

    // Event vector, unused positions stay zero
    assign fc_events_o =
        (soc_periph_pkg::fc_events_t'(timer_irq) << soc_periph_pkg::EVT_TIMER_POS) |
        (soc_periph_pkg::fc_events_t'(ref_rise | ref_fall) << soc_periph_pkg::EVT_REF_CLK_POS) |
        (soc_periph_pkg::fc_events_t'(gpio_irq) << soc_periph_pkg::EVT_GPIO_POS);

endmodule

//--- tests/soc_peripherals_sva.sv
/* APB protocol and event vector assertions, bound into the peripheral subsystem top. */

`timescale 1ns/1ps

module soc_peripherals_sva (
    input logic                       clk_i,
    input logic                       arst_n_i,
    input logic                       psel_i,
    input logic                       penable_i,
    input logic                       pready_o,
    input logic                       pslverr_o,
    input soc_periph_pkg::fc_events_t fc_events_o
);

    // Event bits that may ever be set
    localparam soc_periph_pkg::fc_events_t EVT_USED_MASK =
        (soc_periph_pkg::fc_events_t'(1) << soc_periph_pkg::EVT_TIMER_POS) |
        (soc_periph_pkg::fc_events_t'(1) << soc_periph_pkg::EVT_REF_CLK_POS) |
        (soc_periph_pkg::fc_events_t'(1) << soc_periph_pkg::EVT_GPIO_POS);

    // Number of failed assertions
    int fail_count = 0;

    a_pready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (psel_i && penable_i) |-> pready_o)
        else begin
            fail_count++;
            $error("pready low in an APB access cycle");
        end

    a_pslverr_with_pready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pslverr_o |-> pready_o)
        else begin
            fail_count++;
            $error("pslverr high without pready");
        end

    a_unused_events_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (fc_events_o & ~EVT_USED_MASK) == '0)
        else begin
            fail_count++;
            $error("Unused event bit set");
        end

    a_timer_event_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fc_events_o[soc_periph_pkg::EVT_TIMER_POS] |=>
        !fc_events_o[soc_periph_pkg::EVT_TIMER_POS])
        else begin
            fail_count++;
            $error("Timer event high for two cycles in a row");
        end

endmodule

bind soc_peripherals soc_peripherals_sva sva_inst (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pready_o    ( pready_o    ),
    .pslverr_o   ( pslverr_o   ),
    .fc_events_o ( fc_events_o )
);

//--- tests/tb_soc_peripherals.sv
/* Testbench for the peripheral subsystem: drives APB transfers, GPIO pins and the slow
   reference clock, and checks read data, pins and event bits against the register rules. */

`timescale 1ns/1ps

module tb_soc_peripherals;

    localparam int CLK_PERIOD      = 8;
    localparam int SLOW_HALF       = 20;
    // Roughly a thousand cycles of tests plus ample margin
    localparam int WATCHDOG_CYCLES = 20000;
    localparam int REF_RISES       = 5;

    logic                       clk_i;
    logic                       arst_n_i;
    soc_periph_pkg::apb_addr_t  paddr_i;
    soc_periph_pkg::apb_data_t  pwdata_i;
    logic                       pwrite_i;
    logic                       psel_i;
    logic                       penable_i;
    soc_periph_pkg::apb_data_t  prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    logic                       slow_clk_i;
    soc_periph_pkg::gpio_vec_t  gpio_in_i;
    soc_periph_pkg::gpio_vec_t  gpio_out_o;
    soc_periph_pkg::gpio_vec_t  gpio_dir_o;
    soc_periph_pkg::fc_events_t fc_events_o;

    integer seed;
    int     value_errors;
    int     protocol_errors;

    soc_peripherals soc_peripherals_inst (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .pwrite_i    ( pwrite_i    ),
        .psel_i      ( psel_i      ),
        .penable_i   ( penable_i   ),
        .prdata_o    ( prdata_o    ),
        .pready_o    ( pready_o    ),
        .pslverr_o   ( pslverr_o   ),
        .slow_clk_i  ( slow_clk_i  ),
        .gpio_in_i   ( gpio_in_i   ),
        .gpio_out_o  ( gpio_out_o  ),
        .gpio_dir_o  ( gpio_dir_o  ),
        .fc_events_o ( fc_events_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Slow reference clock driven on the falling edge
    initial begin
        slow_clk_i = 1'b0;
        forever begin
            repeat (SLOW_HALF) @(negedge clk_i);
            slow_clk_i = ~slow_clk_i;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired, tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
            value_errors++;
        end
    endtask

    function automatic soc_periph_pkg::apb_addr_t gpio_addr(input logic [7:0] ofs);
        return {soc_periph_pkg::GPIO_SLOT_ID, ofs};
    endfunction

    function automatic soc_periph_pkg::apb_addr_t timer_addr(input logic [7:0] ofs);
        return {soc_periph_pkg::TIMER_SLOT_ID, ofs};
    endfunction

    // Count after a number of ticks with wrap to zero at the compare value
    function automatic soc_periph_pkg::timer_cnt_t count_after(
        input soc_periph_pkg::timer_cnt_t start,
        input soc_periph_pkg::timer_cnt_t cmp,
        input int ticks
    );
        soc_periph_pkg::timer_cnt_t c;
        c = start;
        for (int i = 0; i < ticks; i++) begin
            c = (c == cmp) ? 32'h0 : c + 32'h1;
        end
        return c;
    endfunction

    // One APB transfer with the response sampled in the middle of the access cycle
    task automatic apb_xfer(input soc_periph_pkg::apb_addr_t addr, input logic write,
                            input soc_periph_pkg::apb_data_t wdata, input logic exp_err,
                            output soc_periph_pkg::apb_data_t rdata);
        logic ready;
        logic err;
        @(negedge clk_i);
        paddr_i   = addr;
        pwrite_i  = write;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk_i);
        penable_i = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata_o;
        ready = pready_o;
        err   = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        assert (ready === 1'b1) else begin
            $display("pready stayed low in the access cycle to address 0x%h", addr);
            protocol_errors++;
        end
        check_value("pslverr_o", 32'(exp_err), 32'(err));
    endtask

    task automatic apb_write(input soc_periph_pkg::apb_addr_t addr,
                             input soc_periph_pkg::apb_data_t wdata);
        soc_periph_pkg::apb_data_t unused;
        apb_xfer(addr, 1'b1, wdata, 1'b0, unused);
    endtask

    task automatic apb_read(input soc_periph_pkg::apb_addr_t addr,
                            output soc_periph_pkg::apb_data_t rdata);
        apb_xfer(addr, 1'b0, 32'h0, 1'b0, rdata);
    endtask

    task automatic wait_event_bit(input int pos, input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!fc_events_o[pos] && cycles < limit);
        assert (fc_events_o[pos]) else begin
            $display("Event bit %0d did not pulse within %0d cycles", pos, limit);
            protocol_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        soc_periph_pkg::apb_data_t  rdata;
        soc_periph_pkg::apb_data_t  dir_exp;
        soc_periph_pkg::apb_data_t  out_exp;
        soc_periph_pkg::apb_data_t  in_val;
        soc_periph_pkg::apb_data_t  mask;
        soc_periph_pkg::apb_data_t  rise_pins;
        soc_periph_pkg::timer_cnt_t cmp;
        int                         cycles;
        int                         pulses;

        seed            = 32'h4169_3bb0;
        value_errors    = 0;
        protocol_errors = 0;
        arst_n_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        pwrite_i        = 1'b0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        gpio_in_i       = '0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // GPIO direction and output registers
        for (int i = 0; i < 4; i++) begin
            dir_exp = $random(seed);
            out_exp = $random(seed);
            apb_write(gpio_addr(soc_periph_pkg::GPIO_DIR_OFS), dir_exp);
            check_value("gpio_dir_o", dir_exp, gpio_dir_o);
            apb_write(gpio_addr(soc_periph_pkg::GPIO_OUT_OFS), out_exp);
            check_value("gpio_out_o", out_exp, gpio_out_o);
            apb_read(gpio_addr(soc_periph_pkg::GPIO_DIR_OFS), rdata);
            check_value("GPIO_DIR", dir_exp, rdata);
            apb_read(gpio_addr(soc_periph_pkg::GPIO_OUT_OFS), rdata);
            check_value("GPIO_OUT", out_exp, rdata);
        end

        // Input readback through the synchronizer and ignored writes
        @(negedge clk_i);
        in_val    = $random(seed);
        gpio_in_i = in_val;
        repeat (2) @(posedge clk_i);
        apb_read(gpio_addr(soc_periph_pkg::GPIO_IN_OFS), rdata);
        check_value("GPIO_IN", in_val, rdata);
        apb_write(gpio_addr(soc_periph_pkg::GPIO_IN_OFS), ~in_val);
        apb_read(gpio_addr(soc_periph_pkg::GPIO_IN_OFS), rdata);
        check_value("GPIO_IN", in_val, rdata);

        // Interrupt on masked rising pins
        @(negedge clk_i);
        gpio_in_i = '0;
        repeat (4) @(negedge clk_i);
        mask      = $random(seed) | 32'h1;
        rise_pins = $random(seed) | 32'h1;
        apb_write(gpio_addr(soc_periph_pkg::GPIO_INTEN_OFS), mask);
        @(negedge clk_i);
        gpio_in_i = rise_pins;
        repeat (2) @(negedge clk_i);
        check_value("fc_events_o[15]", 32'h0, 32'(fc_events_o[soc_periph_pkg::EVT_GPIO_POS]));
        @(negedge clk_i);
        check_value("fc_events_o[15]", 32'h1, 32'(fc_events_o[soc_periph_pkg::EVT_GPIO_POS]));
        apb_read(gpio_addr(soc_periph_pkg::GPIO_INTSTAT_OFS), rdata);
        check_value("GPIO_INTSTAT", rise_pins & mask, rdata);
        apb_write(gpio_addr(soc_periph_pkg::GPIO_INTSTAT_OFS), rise_pins & mask);
        check_value("fc_events_o[15]", 32'h0, 32'(fc_events_o[soc_periph_pkg::EVT_GPIO_POS]));
        apb_read(gpio_addr(soc_periph_pkg::GPIO_INTSTAT_OFS), rdata);
        check_value("GPIO_INTSTAT", 32'h0, rdata);

        // Timer in clock mode with one pulse every cmp+1 cycles
        cmp = 32'd3 + ({$random(seed)} % 18);
        apb_write(timer_addr(soc_periph_pkg::TIMER_CMP_OFS), cmp);
        apb_write(timer_addr(soc_periph_pkg::TIMER_COUNT_OFS), 32'h0);
        apb_write(timer_addr(soc_periph_pkg::TIMER_CTRL_OFS), 32'h1);
        wait_event_bit(soc_periph_pkg::EVT_TIMER_POS, 64, cycles);
        for (int i = 0; i < 3; i++) begin
            wait_event_bit(soc_periph_pkg::EVT_TIMER_POS, 64, cycles);
            check_value("fc_events_o[10] period", cmp + 32'h1, 32'(cycles));
        end

        // Timer in reference mode started right after a slow-clock fall
        apb_write(timer_addr(soc_periph_pkg::TIMER_CTRL_OFS), 32'h0);
        apb_write(timer_addr(soc_periph_pkg::TIMER_CMP_OFS), 32'h2);
        apb_write(timer_addr(soc_periph_pkg::TIMER_COUNT_OFS), 32'h0);
        @(negedge slow_clk_i);
        apb_write(timer_addr(soc_periph_pkg::TIMER_CTRL_OFS), 32'h3);
        repeat (REF_RISES) @(posedge slow_clk_i);
        repeat (6) @(negedge clk_i);
        apb_read(timer_addr(soc_periph_pkg::TIMER_COUNT_OFS), rdata);
        check_value("TIMER_COUNT", count_after(32'h0, 32'h2, REF_RISES), rdata);

        // One event pulse per slow-clock edge
        for (int k = 0; k < 4; k++) begin
            @(slow_clk_i);
            pulses = 0;
            repeat (SLOW_HALF / 2) begin
                @(negedge clk_i);
                if (fc_events_o[soc_periph_pkg::EVT_REF_CLK_POS]) pulses++;
            end
            check_value("fc_events_o[14] pulses", 32'h1, 32'(pulses));
        end

        // Unmapped slot and unknown offsets
        apb_xfer(12'h200, 1'b1, $random(seed), 1'b1, rdata);
        apb_xfer(12'h200, 1'b0, 32'h0, 1'b1, rdata);
        check_value("prdata_o", 32'h0, rdata);
        apb_xfer(gpio_addr(8'h14), 1'b1, $random(seed), 1'b1, rdata);
        apb_xfer(gpio_addr(8'h14), 1'b0, 32'h0, 1'b1, rdata);
        check_value("prdata_o", 32'h0, rdata);
        apb_xfer(timer_addr(8'h0C), 1'b1, $random(seed), 1'b1, rdata);
        apb_xfer(timer_addr(8'h0C), 1'b0, 32'h0, 1'b1, rdata);
        check_value("prdata_o", 32'h0, rdata);
        apb_read(gpio_addr(soc_periph_pkg::GPIO_DIR_OFS), rdata);
        check_value("GPIO_DIR", dir_exp, rdata);
        apb_read(gpio_addr(soc_periph_pkg::GPIO_OUT_OFS), rdata);
        check_value("GPIO_OUT", out_exp, rdata);
        apb_read(timer_addr(soc_periph_pkg::TIMER_CMP_OFS), rdata);
        check_value("TIMER_CMP", 32'h2, rdata);

        $display("Test summary: %0d value errors, %0d protocol errors, %0d assertion failures",
                 value_errors, protocol_errors, soc_peripherals_inst.sva_inst.fail_count);
        if (value_errors == 0 && protocol_errors == 0 &&
            soc_peripherals_inst.sva_inst.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- soc_peripherals.f
common/soc_periph_pkg.sv
hdl/periph_apb_decoder.sv
gpio/gpio_input_sync.sv
gpio/gpio_apb_regs.sv
timer/apb_timer.sv
hdl/ref_clk_edge_detect.sv
hdl/soc_peripherals.sv
tests/soc_peripherals_sva.sv
tests/tb_soc_peripherals.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc_peripherals -f soc_peripherals.f -o sim_soc_peripherals

# The log decides the result, so a failing run must not stop the script here
./obj_dir/sim_soc_peripherals > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
else
    exit 1
fi
